// ==== hdl/fetch_pkg.sv ====
package fetch_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// datapath
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam int DATA_WIDTH = 16;
	localparam int N_CHANNELS = 16;
	localparam int N_OPERANDS = 2;   // operands a and b

	typedef logic signed [DATA_WIDTH - 1 : 0] data_t;
	typedef logic [$clog2(N_CHANNELS) - 1 : 0] chan_addr_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// scoreboard and commit tracking
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	typedef logic [3 : 0] pend_count_t;   // writes promised, not yet written back
	typedef logic [8 : 0] commit_id_t;

endpackage

// ==== hdl/instr_pkg.sv ====
package instr_pkg;

	typedef logic [4 : 0] op_t;   // carried through unchanged

	// channel address, or register-source code when the reg flag is set
	typedef logic [3 : 0] src_sel_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// register-source codes
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	localparam src_sel_t SRC_REG_0      = 4'd0;
	localparam src_sel_t SRC_REG_1      = 4'd1;
	localparam src_sel_t SRC_CONST_HALF = 4'd3;   // 2^(w-2)
	localparam src_sel_t SRC_CONST_MIN  = 4'd4;   // top bit only

	// substage FSM
	typedef enum logic {
		FETCH_IDLE,
		FETCH_WAIT
	} fetch_state_t;

endpackage

// ==== hdl/stage_if.sv ====
`timescale 1ns/1ps

interface stage_if;
	import fetch_pkg::*;
	import instr_pkg::*;

	logic valid;
	logic ready;

	op_t op;
	chan_addr_t dest;
	logic writes_channel;
	data_t register_0;
	data_t register_1;

	// one slot per operand, index 0 is a
	src_sel_t [N_OPERANDS - 1 : 0] src;
	logic [N_OPERANDS - 1 : 0] src_reg;
	logic [N_OPERANDS - 1 : 0] arg_needed;
	data_t [N_OPERANDS - 1 : 0] arg;

	modport upstream (
		output valid, op, dest, writes_channel, register_0, register_1,
		output src, src_reg, arg_needed, arg,
		input ready
	);

	modport downstream (
		input valid, op, dest, writes_channel, register_0, register_1,
		input src, src_reg, arg_needed, arg,
		output ready
	);

endinterface

// ==== hdl/channel_file.sv ====
`timescale 1ns/1ps

module channel_file (
	input logic clk,
	input logic reset,
	input logic channel_write_enable,
	input fetch_pkg::chan_addr_t channel_write_addr,
	input fetch_pkg::data_t channel_write_val,
	input fetch_pkg::chan_addr_t read_addr_a,
	input fetch_pkg::chan_addr_t read_addr_b,
	output fetch_pkg::data_t read_val_a,
	output fetch_pkg::data_t read_val_b
);
	import fetch_pkg::*;

	data_t channels [N_CHANNELS];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < N_CHANNELS; i++) begin
				channels[i] <= '0;
			end
		end else if (channel_write_enable) begin
			channels[channel_write_addr] <= channel_write_val;
		end
	end

	// write-through is handled by forwarding in the substages
	assign read_val_a = channels[read_addr_a];
	assign read_val_b = channels[read_addr_b];

endmodule

// ==== hdl/pending_write_counter.sv ====
`timescale 1ns/1ps

module pending_write_counter (
	input logic clk,
	input logic reset,
	input logic add_pending,
	input fetch_pkg::chan_addr_t add_addr,
	input logic channel_write_enable,
	input fetch_pkg::chan_addr_t channel_write_addr,
	input fetch_pkg::chan_addr_t query_addr,
	output fetch_pkg::pend_count_t pending
);
	import fetch_pkg::*;

	pend_count_t counts [N_CHANNELS];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < N_CHANNELS; i++) begin
				counts[i] <= '0;
			end
		end else begin
			for (int i = 0; i < N_CHANNELS; i++) begin
				case ({add_pending && add_addr == chan_addr_t'(i),
						channel_write_enable && channel_write_addr == chan_addr_t'(i)})
					2'b10: begin
						counts[i] <= counts[i] + 1'b1;
					end
					2'b01: begin
						if (counts[i] != '0)   // stray write-back, no underflow
							counts[i] <= counts[i] - 1'b1;
					end
					default: begin
						counts[i] <= counts[i];   // idle, or promise and write cancel
					end
				endcase
			end
		end
	end

	assign pending = counts[query_addr];

endmodule

// ==== hdl/fetch_control.sv ====
`timescale 1ns/1ps

module fetch_control (
	input logic clk,
	input logic reset,
	input logic in_valid,
	input logic resolvable_now,
	input logic resolvable_latched,
	input logic out_ready,
	output logic in_ready,
	output logic take_in,
	output logic load_out,
	output logic out_valid,
	output logic hold_select
);
	import instr_pkg::*;

	fetch_state_t state;
	logic out_free;

	assign out_free = !out_valid || out_ready;   // output empty or drained this cycle
	assign hold_select = (state == FETCH_WAIT);
	assign in_ready = !hold_select && out_free;
	assign take_in = in_valid && in_ready;

	// single-cycle pass on accept, or release of the waiting instruction
	assign load_out = (take_in && resolvable_now)
			|| (hold_select && resolvable_latched && out_free);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= FETCH_IDLE;
		end else begin
			case (state)
				FETCH_IDLE: begin
					if (take_in && !resolvable_now)
						state <= FETCH_WAIT;
				end
				FETCH_WAIT: begin
					if (load_out)
						state <= FETCH_IDLE;
				end
				default: begin
					state <= FETCH_IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			out_valid <= 1'b0;
		else if (load_out)
			out_valid <= 1'b1;
		else if (out_ready)
			out_valid <= 1'b0;
	end

endmodule

// ==== hdl/operand_substage.sv ====
`timescale 1ns/1ps

module operand_substage #(
	parameter int operand_index = 0
) (
	input logic clk,
	input logic reset,
	input logic channel_write_enable,
	input fetch_pkg::chan_addr_t channel_write_addr,
	input fetch_pkg::data_t channel_write_val,
	input fetch_pkg::data_t read_val,
	output fetch_pkg::chan_addr_t read_addr,
	stage_if.downstream up,
	stage_if.upstream down
);
	import fetch_pkg::*;
	import instr_pkg::*;

	logic take_in, load_out, hold_select;
	logic resolvable_now, resolvable_latched;
	logic channel_ok, incoming;
	pend_count_t pending;

	// waiting instruction
	op_t lat_op;
	chan_addr_t lat_dest;
	logic lat_writes_channel;
	data_t lat_register_0, lat_register_1;
	src_sel_t [N_OPERANDS - 1 : 0] lat_src;
	logic [N_OPERANDS - 1 : 0] lat_src_reg, lat_arg_needed;
	data_t [N_OPERANDS - 1 : 0] lat_arg;

	// instruction being worked on this cycle
	op_t sel_op;
	chan_addr_t sel_dest;
	logic sel_writes_channel;
	data_t sel_register_0, sel_register_1;
	src_sel_t sel_src;
	logic sel_src_reg, sel_arg_needed;
	data_t [N_OPERANDS - 1 : 0] sel_arg;
	data_t reg_value, fetched;

	always_ff @(posedge clk) begin
		if (take_in) begin
			lat_op <= up.op;
			lat_dest <= up.dest;
			lat_writes_channel <= up.writes_channel;
			lat_register_0 <= up.register_0;
			lat_register_1 <= up.register_1;
			lat_src <= up.src;
			lat_src_reg <= up.src_reg;
			lat_arg_needed <= up.arg_needed;
			lat_arg <= up.arg;
		end
	end

	assign sel_op = hold_select ? lat_op : up.op;
	assign sel_dest = hold_select ? lat_dest : up.dest;
	assign sel_writes_channel = hold_select ? lat_writes_channel : up.writes_channel;
	assign sel_register_0 = hold_select ? lat_register_0 : up.register_0;
	assign sel_register_1 = hold_select ? lat_register_1 : up.register_1;
	assign sel_src = hold_select ? lat_src[operand_index] : up.src[operand_index];
	assign sel_src_reg = hold_select ? lat_src_reg[operand_index] : up.src_reg[operand_index];
	assign sel_arg_needed = hold_select ? lat_arg_needed[operand_index]
			: up.arg_needed[operand_index];
	assign sel_arg = hold_select ? lat_arg : up.arg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// hazard check and forwarding
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign read_addr = chan_addr_t'(sel_src);
	assign incoming = (pending == pend_count_t'(1)) && channel_write_enable
			&& (channel_write_addr == read_addr);
	assign channel_ok = (pending == '0) || incoming;

	assign resolvable_now = !up.arg_needed[operand_index] || up.src_reg[operand_index]
			|| channel_ok;
	assign resolvable_latched = !lat_arg_needed[operand_index] || lat_src_reg[operand_index]
			|| channel_ok;

	always_comb begin
		case (sel_src)
			SRC_REG_0: reg_value = sel_register_0;
			SRC_REG_1: reg_value = sel_register_1;
			SRC_CONST_HALF: reg_value = data_t'(1) <<< (DATA_WIDTH - 2);
			SRC_CONST_MIN: reg_value = {1'b1, {(DATA_WIDTH - 1){1'b0}}};
			default: reg_value = '0;
		endcase
	end

	assign fetched = !sel_arg_needed ? data_t'(0)
			: sel_src_reg ? reg_value
			: incoming ? channel_write_val : read_val;

	always_ff @(posedge clk) begin
		if (load_out) begin
			down.op <= sel_op;
			down.dest <= sel_dest;
			down.writes_channel <= sel_writes_channel;
			down.register_0 <= sel_register_0;
			down.register_1 <= sel_register_1;
			down.src <= hold_select ? lat_src : up.src;
			down.src_reg <= hold_select ? lat_src_reg : up.src_reg;
			down.arg_needed <= hold_select ? lat_arg_needed : up.arg_needed;
			for (int i = 0; i < N_OPERANDS; i++) begin
				down.arg[i] <= (i == operand_index) ? fetched : sel_arg[i];
			end
		end
	end

	fetch_control u_control (
		.clk(clk),
		.reset(reset),
		.in_valid(up.valid),
		.resolvable_now(resolvable_now),
		.resolvable_latched(resolvable_latched),
		.out_ready(down.ready),
		.in_ready(up.ready),
		.take_in(take_in),
		.load_out(load_out),
		.out_valid(down.valid),
		.hold_select(hold_select)
	);

	// promise counted when the instruction leaves this substage
	pending_write_counter u_pending (
		.clk(clk),
		.reset(reset),
		.add_pending(load_out && sel_writes_channel),
		.add_addr(sel_dest),
		.channel_write_enable(channel_write_enable),
		.channel_write_addr(channel_write_addr),
		.query_addr(read_addr),
		.pending(pending)
	);

endmodule

// ==== hdl/operand_fetch.sv ====
`timescale 1ns/1ps

module operand_fetch (
	input logic clk,
	input logic reset,

	input logic in_valid,
	output logic in_ready,
	input instr_pkg::op_t op_in,
	input fetch_pkg::chan_addr_t dest_in,
	input logic writes_channel_in,
	input fetch_pkg::data_t register_0_in,
	input fetch_pkg::data_t register_1_in,
	input instr_pkg::src_sel_t src_a,
	input logic src_a_reg,
	input logic arg_a_needed,
	input instr_pkg::src_sel_t src_b,
	input logic src_b_reg,
	input logic arg_b_needed,

	output logic out_valid,
	input logic out_ready,
	output instr_pkg::op_t op_out,
	output fetch_pkg::chan_addr_t dest_out,
	output logic writes_channel_out,
	output fetch_pkg::data_t arg_a_out,
	output fetch_pkg::data_t arg_b_out,
	output fetch_pkg::commit_id_t commit_id_out,

	input logic channel_write_enable,
	input fetch_pkg::chan_addr_t channel_write_addr,
	input fetch_pkg::data_t channel_write_val
);
	import fetch_pkg::*;

	stage_if in_bus ();
	stage_if mid_bus ();
	stage_if out_bus ();

	chan_addr_t read_addr_a, read_addr_b;
	data_t read_val_a, read_val_b;
	commit_id_t commit_id;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// port mapping
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	assign in_bus.valid = in_valid;
	assign in_ready = in_bus.ready;
	assign in_bus.op = op_in;
	assign in_bus.dest = dest_in;
	assign in_bus.writes_channel = writes_channel_in;
	assign in_bus.register_0 = register_0_in;
	assign in_bus.register_1 = register_1_in;
	assign in_bus.src = {src_b, src_a};
	assign in_bus.src_reg = {src_b_reg, src_a_reg};
	assign in_bus.arg_needed = {arg_b_needed, arg_a_needed};
	assign in_bus.arg = '0;   // slots filled by the substages

	assign out_valid = out_bus.valid;
	assign out_bus.ready = out_ready;
	assign op_out = out_bus.op;
	assign dest_out = out_bus.dest;
	assign writes_channel_out = out_bus.writes_channel;
	assign arg_a_out = out_bus.arg[0];
	assign arg_b_out = out_bus.arg[1];

	// counts channel writers already handed to execute
	always_ff @(posedge clk) begin
		if (reset)
			commit_id <= '0;
		else if (out_bus.valid && out_ready && out_bus.writes_channel)
			commit_id <= commit_id + 1'b1;
	end

	assign commit_id_out = commit_id;

	channel_file u_channels (
		.clk(clk),
		.reset(reset),
		.channel_write_enable(channel_write_enable),
		.channel_write_addr(channel_write_addr),
		.channel_write_val(channel_write_val),
		.read_addr_a(read_addr_a),
		.read_addr_b(read_addr_b),
		.read_val_a(read_val_a),
		.read_val_b(read_val_b)
	);

	operand_substage #(.operand_index(0)) u_fetch_a (
		.clk(clk),
		.reset(reset),
		.channel_write_enable(channel_write_enable),
		.channel_write_addr(channel_write_addr),
		.channel_write_val(channel_write_val),
		.read_val(read_val_a),
		.read_addr(read_addr_a),
		.up(in_bus.downstream),
		.down(mid_bus.upstream)
	);

	operand_substage #(.operand_index(1)) u_fetch_b (
		.clk(clk),
		.reset(reset),
		.channel_write_enable(channel_write_enable),
		.channel_write_addr(channel_write_addr),
		.channel_write_val(channel_write_val),
		.read_val(read_val_b),
		.read_addr(read_addr_b),
		.up(mid_bus.downstream),
		.down(out_bus.upstream)
	);

endmodule

// ==== testbench/operand_fetch_tb.sv ====
`timescale 1ns/1ps

module operand_fetch_tb;
	import fetch_pkg::*;
	import instr_pkg::*;

	localparam int N_INSTR = 200;
	localparam int TIMEOUT_CYCLES = 40 * N_INSTR + 100;

	typedef struct {
		op_t op;
		chan_addr_t dest;
		logic writes_channel;
		data_t arg_a;
		data_t arg_b;
		commit_id_t commit_id;
	} expected_t;

	logic clk = 1'b0;
	logic reset, in_valid, in_ready, writes_channel_in;
	op_t op_in;
	chan_addr_t dest_in;
	data_t register_0_in, register_1_in;
	src_sel_t src_a, src_b;
	logic src_a_reg, arg_a_needed, src_b_reg, arg_b_needed;
	logic out_valid, out_ready, writes_channel_out;
	op_t op_out;
	chan_addr_t dest_out;
	data_t arg_a_out, arg_b_out;
	commit_id_t commit_id_out;
	logic channel_write_enable;
	chan_addr_t channel_write_addr;
	data_t channel_write_val;

	logic [31:0] lfsr_state = 32'h2ef2;
	data_t model_chan [N_CHANNELS];   // in-order view of the channels
	expected_t expected_q [$];
	chan_addr_t wb_addr_q [$];
	data_t wb_val_q [$];
	int writer_count = 0;
	int sent = 0;
	int outputs_seen = 0;
	int check_count = 0;
	int error_count = 0;
	int cycle_count = 0;
	int wb_delay = 0;
	logic input_taken = 1'b0;

	operand_fetch u_operand_fetch (.*);

	always #10 clk = ~clk;

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
	endfunction

	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);
			r = {r[30:0], lfsr_state[0]};
		end
		return r;
	endfunction

	function automatic data_t preload_value(input int i);
		return data_t'(16'h0500 + i * 16'h0123);
	endfunction

	// operand as the in-order model sees it at accept time
	function automatic data_t expected_operand(input src_sel_t src, input logic is_reg,
			input logic needed, input data_t r0, input data_t r1);
		if (!needed)
			return '0;
		if (!is_reg)
			return model_chan[src];
		case (src)
			4'd0: return r0;
			4'd1: return r1;
			4'd3: return 16'h4000;
			4'd4: return 16'h8000;
			default: return '0;
		endcase
	endfunction

	task automatic generate_instruction();
		op_in = op_t'(random_bits(5));
		dest_in = chan_addr_t'(random_bits(3));   // low channels only so hazards stay frequent
		writes_channel_in = 1'(random_bits(1));
		register_0_in = data_t'(random_bits(16));
		register_1_in = data_t'(random_bits(16));
		src_a_reg = 1'(random_bits(1));
		src_a = src_sel_t'(random_bits(4));
		arg_a_needed = (random_bits(2) != 0);
		src_b_reg = 1'(random_bits(1));
		src_b = src_sel_t'(random_bits(4));
		arg_b_needed = (random_bits(2) != 0);
	endtask

	task automatic present_instruction();
		if (!in_valid || input_taken) begin
			input_taken = 1'b0;
			if (sent < N_INSTR) begin
				generate_instruction();
				in_valid = 1'b1;
				sent++;
			end else begin
				in_valid = 1'b0;
			end
		end
	endtask

	task automatic choose_out_ready();
		out_ready = (random_bits(2) != 0) && (wb_addr_q.size() < 4);   // bound the promises
	endtask

	task automatic issue_write_back();
		if (wb_delay != 0) begin
			wb_delay--;
			channel_write_enable = 1'b0;
		end else if (wb_addr_q.size() > 0) begin
			channel_write_enable = 1'b1;
			channel_write_addr = wb_addr_q.pop_front();
			channel_write_val = wb_val_q.pop_front();
			wb_delay = random_bits(2);
		end else begin
			channel_write_enable = 1'b0;
		end
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// handshake monitor and comparison
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

	always @(posedge clk) begin
		expected_t exp;
		expected_t got;
		if (!reset && in_valid && in_ready) begin
			exp.op = op_in;
			exp.dest = dest_in;
			exp.writes_channel = writes_channel_in;
			exp.arg_a = expected_operand(src_a, src_a_reg, arg_a_needed,
					register_0_in, register_1_in);
			exp.arg_b = expected_operand(src_b, src_b_reg, arg_b_needed,
					register_0_in, register_1_in);
			exp.commit_id = commit_id_t'(writer_count);
			expected_q.push_back(exp);
			if (writes_channel_in) begin   // own write lands after its reads
				model_chan[dest_in] = data_t'(writer_count * 37);
				writer_count++;
			end
			input_taken = 1'b1;
		end
		if (!reset && out_valid && out_ready) begin
			outputs_seen++;
			if (writes_channel_out) begin
				wb_addr_q.push_back(dest_out);
				wb_val_q.push_back(data_t'(commit_id_out * 37));
			end
			if (expected_q.size() == 0) begin
				$display("output at %0t has no matching accepted input", $time);
				error_count++;
			end else begin
				exp = expected_q.pop_front();
				got.op = op_out;
				got.dest = dest_out;
				got.writes_channel = writes_channel_out;
				got.arg_a = arg_a_out;
				got.arg_b = arg_b_out;
				got.commit_id = commit_id_out;
				check_count += 6;
				if (got.op != exp.op) begin
					$display("ERROR %0t op_out: expected %h, got %h", $time,
							exp.op, got.op);
					error_count++;
				end
				if (got.dest != exp.dest) begin
					$display("ERROR %0t dest_out: expected %h, got %h", $time,
							exp.dest, got.dest);
					error_count++;
				end
				if (got.writes_channel != exp.writes_channel) begin
					$display("ERROR %0t writes_channel_out: expected %b, got %b", $time,
							exp.writes_channel, got.writes_channel);
					error_count++;
				end
				if (got.arg_a != exp.arg_a) begin
					$display("ERROR %0t arg_a_out: expected %h, got %h", $time,
							exp.arg_a, got.arg_a);
					error_count++;
				end
				if (got.arg_b != exp.arg_b) begin
					$display("ERROR %0t arg_b_out: expected %h, got %h", $time,
							exp.arg_b, got.arg_b);
					error_count++;
				end
				if (got.commit_id != exp.commit_id) begin
					$display("ERROR %0t commit_id_out: expected %0d, got %0d", $time,
							exp.commit_id, got.commit_id);
					error_count++;
				end
			end
		end
	end

	initial begin
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycle_count++;
		end
		$display("timeout after %0d cycles, %0d of %0d outputs received",
				cycle_count, outputs_seen, N_INSTR);
		$display("STATUS: FAIL");
		$finish;
	end

	initial begin
		reset = 1'b1;
		in_valid = 1'b0;
		op_in = '0;
		dest_in = '0;
		writes_channel_in = 1'b0;
		register_0_in = '0;
		register_1_in = '0;
		src_a = '0;
		src_a_reg = 1'b0;
		arg_a_needed = 1'b0;
		src_b = '0;
		src_b_reg = 1'b0;
		arg_b_needed = 1'b0;
		out_ready = 1'b0;
		channel_write_enable = 1'b0;
		channel_write_addr = '0;
		channel_write_val = '0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;

		for (int i = 0; i < N_CHANNELS; i++) begin   // preload while nothing is in flight
			channel_write_enable = 1'b1;
			channel_write_addr = chan_addr_t'(i);
			channel_write_val = preload_value(i);
			model_chan[i] = preload_value(i);
			@(negedge clk);
		end
		channel_write_enable = 1'b0;

		while (outputs_seen < N_INSTR) begin
			@(negedge clk);
			present_instruction();
			choose_out_ready();
			issue_write_back();
		end
		channel_write_enable = 1'b0;
		out_ready = 1'b1;
		repeat (10) @(negedge clk);   // catch stray extra outputs

		if (expected_q.size() != 0) begin
			$display("%0d accepted instructions never came out", expected_q.size());
			error_count++;
		end
		$display("checks %0d, errors %0d, outputs %0d of %0d",
				check_count, error_count, outputs_seen, N_INSTR);
		if (error_count == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

endmodule

// ==== project.f ====
hdl/fetch_pkg.sv
hdl/instr_pkg.sv
hdl/stage_if.sv
hdl/channel_file.sv
hdl/pending_write_counter.sv
hdl/fetch_control.sv
hdl/operand_substage.sv
hdl/operand_fetch.sv
testbench/operand_fetch_tb.sv
